// File: rtl/amc_pkg.sv
// Shared sample, velocity and vector types plus the fixed-point constants of the auto mode path
package amc_pkg;

    // Number of acceleration axes handled in parallel
    localparam int NUM_AXES = 3;

    // Raw IMU acceleration, one LSB is 0.01 m/s^2
    typedef logic signed [15:0] accel_t;

    // Three-axis sample as delivered by the IMU stream
    typedef struct packed {
        accel_t x;
        accel_t y;
        accel_t z;
    } imu_sample_t;

    // Signed Q16.16 value used for offsets, zeroed accelerations and velocity
    typedef logic signed [31:0] fix_t;

    // Integer part of a Q16.16 velocity
    typedef logic signed [15:0] vel_t;

    typedef struct packed {
        vel_t x;
        vel_t y;
        vel_t z;
    } vel_vec_t;

    // The time step of 0.0004 is built from these right shifts
    // 0.01 m/s^2 per LSB times 40 ms per update
    localparam int NUM_DT_SHIFTS = 11;
    localparam int DT_SHIFTS [NUM_DT_SHIFTS] = '{12, 13, 15, 19, 20, 22, 23, 25, 26, 27, 31};

    // One velocity unit in Q16.16, the step used to bleed velocity toward zero
    localparam fix_t BLEED_STEP = 32'sh0001_0000;

endpackage

// File: rtl/auto_mode_sequencer.sv
// Auto mode control FSM with start latch, throttle latch, sample intake, result registers and hold timer
`timescale 1ns/1ps

module auto_mode_sequencer import amc_pkg::*; #(
    parameter int HOLD_TICKS = 10000
) (
    input  logic        us_clk,
    input  logic        resetn,
    input  logic        imu_good,
    input  logic        start_signal,
    input  logic [7:0]  throttle_in,
    input  logic        imu_valid,
    input  imu_sample_t imu_sample,
    output logic        imu_ready,
    output logic        sample_valid,
    output imu_sample_t sample_data,
    input  logic        sample_ready,
    input  logic        vec_valid,
    input  vel_vec_t    vec_data,
    output logic        vec_ready,
    output logic [7:0]  throttle_out,
    output logic        active,
    output logic        complete,
    output vel_vec_t    velocity,
    output logic        hold_window
);

    localparam int CNT_W = $clog2(HOLD_TICKS + 1);

    typedef enum logic [4:0] {
        S_INIT     = 5'b00001,
        S_IDLE     = 5'b00010,
        S_SAMPLE   = 5'b00100,
        S_PROCESS  = 5'b01000,
        S_COMPLETE = 5'b10000
    } state_t;

    state_t           state;
    state_t           state_nx;
    logic             start_flag;
    logic             imu_fire;
    logic             vec_fire;
    logic [CNT_W-1:0] hold_cnt;

    assign imu_ready   = (state == S_SAMPLE);
    assign vec_ready   = (state == S_PROCESS);
    assign imu_fire    = imu_valid && imu_ready;
    assign vec_fire    = vec_valid && vec_ready;
    assign hold_window = (hold_cnt != '0);

    always_comb begin
        state_nx = state;
        case (state)
            S_INIT:     if (imu_good) state_nx = S_IDLE;
            S_IDLE:     if (start_flag) state_nx = S_SAMPLE;
            S_SAMPLE:   if (imu_fire) state_nx = S_PROCESS;
            S_PROCESS:  if (vec_fire) state_nx = S_COMPLETE;
            S_COMPLETE: state_nx = S_IDLE;
            default:    state_nx = S_INIT;
        endcase
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            state        <= S_INIT;
            start_flag   <= 1'b0;
            active       <= 1'b0;
            complete     <= 1'b0;
            throttle_out <= '0;
            sample_valid <= 1'b0;
            velocity     <= '0;
            hold_cnt     <= '0;
        end else begin
            state    <= state_nx;
            complete <= vec_fire;

            // A start request is remembered until the IMU sample is taken
            if (imu_fire)
                start_flag <= 1'b0;
            else if (start_signal)
                start_flag <= 1'b1;

            if (imu_fire) begin
                throttle_out <= throttle_in;
                active       <= 1'b1;
                sample_valid <= 1'b1;
            end else begin
                if (vec_fire)
                    active <= 1'b0;
                if (sample_valid && sample_ready)
                    sample_valid <= 1'b0;
            end

            if (vec_fire)
                velocity <= vec_data;

            // The window opens on the cycle after the complete pulse
            if (state == S_COMPLETE)
                hold_cnt <= CNT_W'(HOLD_TICKS);
            else if (hold_cnt != '0)
                hold_cnt <= hold_cnt - 1'b1;
        end
    end

    always_ff @(posedge us_clk) begin
        if (imu_fire)
            sample_data <= imu_sample;
    end

    a_complete_single: assert property (
        @(posedge us_clk) disable iff (!resetn) complete |=> !complete
    );

endmodule

// File: rtl/imu_axis_splitter.sv
// Splitter that hands each component of one buffered three-axis sample to its own integrator
`timescale 1ns/1ps

module imu_axis_splitter import amc_pkg::*; (
    input  logic                    us_clk,
    input  logic                    resetn,
    input  logic                    sample_valid,
    input  imu_sample_t             sample_data,
    output logic                    sample_ready,
    output logic [NUM_AXES-1:0]     axis_valid,
    output accel_t [NUM_AXES-1:0]   axis_accel,
    input  logic [NUM_AXES-1:0]     axis_ready
);

    logic                buf_valid;
    imu_sample_t         buf_q;
    logic [NUM_AXES-1:0] taken;
    logic [NUM_AXES-1:0] axis_fire;
    logic [NUM_AXES-1:0] taken_nx;

    assign sample_ready = !buf_valid;
    assign axis_valid   = {NUM_AXES{buf_valid}} & ~taken;
    assign axis_fire    = axis_valid & axis_ready;
    assign taken_nx     = taken | axis_fire;

    // Axis 0 is x, axis 1 is y, axis 2 is z
    assign axis_accel[0] = buf_q.x;
    assign axis_accel[1] = buf_q.y;
    assign axis_accel[2] = buf_q.z;

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            buf_valid <= 1'b0;
            taken     <= '0;
        end else if (sample_valid && sample_ready) begin
            buf_valid <= 1'b1;
            taken     <= '0;
        end else if (&taken_nx) begin
            // Every axis has its component, so the buffer is free again
            buf_valid <= 1'b0;
            taken     <= '0;
        end else begin
            taken <= taken_nx;
        end
    end

    always_ff @(posedge us_clk) begin
        if (sample_valid && sample_ready)
            buf_q <= sample_data;
    end

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_once
        a_axis_once: assert property (
            @(posedge us_clk) disable iff (!resetn)
            axis_fire[i] |=> !axis_fire[i] until (sample_valid && sample_ready)
        );
    end

endmodule

// File: rtl/axis_velocity_integrator.sv
// Per-axis integrator with zero-offset removal, deadband bleed and shift-sum velocity update
`timescale 1ns/1ps

module axis_velocity_integrator import amc_pkg::*; #(
    parameter int DEADBAND = 20
) (
    input  logic   us_clk,
    input  logic   resetn,
    input  logic   axis_valid,
    input  accel_t axis_accel,
    output logic   axis_ready,
    output logic   vel_valid,
    output fix_t   vel_fix,
    input  logic   vel_ready
);

    localparam fix_t DB_FIX = fix_t'(DEADBAND * 65536);

    logic offset_valid;
    fix_t offset_q;
    logic s1_valid;
    fix_t zeroed_q;
    fix_t vel_q;
    fix_t acc_fix;
    fix_t offset_use;
    vel_t vel_int;
    logic accept;
    logic in_deadband;

    // Multiply by the time step as a sum of arithmetic right shifts
    function automatic fix_t dt_scale(input fix_t a);
        fix_t sum;
        sum = '0;
        for (int k = 0; k < NUM_DT_SHIFTS; k++) begin
            sum = sum + (a >>> DT_SHIFTS[k]);
        end
        return sum;
    endfunction

    // Only one item is in flight, from intake until the velocity is taken
    assign axis_ready = !s1_valid && !vel_valid;
    assign accept     = axis_valid && axis_ready;
    assign vel_fix    = vel_q;
    assign vel_int    = vel_q[31:16];

    assign acc_fix     = {axis_accel, 16'h0000};
    // The very first sample is its own offset and so zeroes to nothing
    assign offset_use  = offset_valid ? offset_q : acc_fix;
    assign in_deadband = (zeroed_q <= DB_FIX) && (zeroed_q >= -DB_FIX);

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            offset_valid <= 1'b0;
            s1_valid     <= 1'b0;
            vel_valid    <= 1'b0;
            vel_q        <= '0;
        end else begin
            s1_valid <= accept;
            if (accept)
                offset_valid <= 1'b1;

            if (s1_valid) begin
                vel_valid <= 1'b1;
                if (!in_deadband)
                    vel_q <= vel_q + dt_scale(zeroed_q);
                else if (vel_int > 0)
                    vel_q <= vel_q - BLEED_STEP;
                else if (vel_int < 0)
                    vel_q <= vel_q + BLEED_STEP;
            end else if (vel_valid && vel_ready) begin
                vel_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge us_clk) begin
        if (accept) begin
            zeroed_q <= acc_fix - offset_use;
            if (!offset_valid)
                offset_q <= acc_fix;
        end
    end

    a_vel_stable: assert property (
        @(posedge us_clk) disable iff (!resetn)
        (vel_valid && !vel_ready) |=> (vel_valid && $stable(vel_fix))
    );

endmodule

// File: rtl/velocity_collector.sv
// Collector that joins one integer velocity per axis into a vector for the sequencer
`timescale 1ns/1ps

module velocity_collector import amc_pkg::*; (
    input  logic                  us_clk,
    input  logic                  resetn,
    input  logic [NUM_AXES-1:0]   vel_valid,
    input  fix_t [NUM_AXES-1:0]   vel_fix,
    output logic [NUM_AXES-1:0]   vel_ready,
    output logic                  vec_valid,
    output vel_vec_t              vec_data,
    input  logic                  vec_ready
);

    logic [NUM_AXES-1:0]   full;
    logic [NUM_AXES-1:0]   vel_fire;
    vel_t [NUM_AXES-1:0]   vel_q;

    assign vel_ready = ~full;
    assign vel_fire  = vel_valid & vel_ready;

    assign vec_data.x = vel_q[0];
    assign vec_data.y = vel_q[1];
    assign vec_data.z = vel_q[2];

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            full      <= '0;
            vec_valid <= 1'b0;
        end else if (vec_valid && vec_ready) begin
            full      <= '0;
            vec_valid <= 1'b0;
        end else begin
            full <= full | vel_fire;
            // Offered one cycle after the last axis has arrived
            vec_valid <= &full;
        end
    end

    // Only the integer part of each Q16.16 velocity is kept
    always_ff @(posedge us_clk) begin
        for (int i = 0; i < NUM_AXES; i++) begin
            if (vel_fire[i])
                vel_q[i] <= vel_fix[i][31:16];
        end
    end

endmodule

// File: rtl/auto_mode_top.sv
// Top level of the auto mode path joining sequencer, splitter, per-axis integrators and collector
`timescale 1ns/1ps

module auto_mode_top import amc_pkg::*; #(
    parameter int DEADBAND   = 20,
    parameter int HOLD_TICKS = 10000
) (
    input  logic        us_clk,
    input  logic        resetn,
    input  logic        imu_good,
    input  logic        start_signal,
    input  logic [7:0]  throttle_in,
    input  logic        imu_valid,
    input  imu_sample_t imu_sample,
    output logic        imu_ready,
    output logic [7:0]  throttle_out,
    output logic        active,
    output logic        complete,
    output vel_vec_t    velocity,
    output logic        hold_window
);

    logic                  sample_valid;
    logic                  sample_ready;
    imu_sample_t           sample_data;
    logic [NUM_AXES-1:0]   axis_valid;
    logic [NUM_AXES-1:0]   axis_ready;
    accel_t [NUM_AXES-1:0] axis_accel;
    logic [NUM_AXES-1:0]   vel_valid;
    logic [NUM_AXES-1:0]   vel_ready;
    fix_t [NUM_AXES-1:0]   vel_fix;
    logic                  vec_valid;
    logic                  vec_ready;
    vel_vec_t              vec_data;

    auto_mode_sequencer #(
        .HOLD_TICKS (HOLD_TICKS)
    ) u_seq (
        .us_clk       (us_clk),
        .resetn       (resetn),
        .imu_good     (imu_good),
        .start_signal (start_signal),
        .throttle_in  (throttle_in),
        .imu_valid    (imu_valid),
        .imu_sample   (imu_sample),
        .imu_ready    (imu_ready),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .sample_ready (sample_ready),
        .vec_valid    (vec_valid),
        .vec_data     (vec_data),
        .vec_ready    (vec_ready),
        .throttle_out (throttle_out),
        .active       (active),
        .complete     (complete),
        .velocity     (velocity),
        .hold_window  (hold_window)
    );

    imu_axis_splitter u_split (
        .us_clk       (us_clk),
        .resetn       (resetn),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .sample_ready (sample_ready),
        .axis_valid   (axis_valid),
        .axis_accel   (axis_accel),
        .axis_ready   (axis_ready)
    );

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        axis_velocity_integrator #(
            .DEADBAND (DEADBAND)
        ) u_integ (
            .us_clk     (us_clk),
            .resetn     (resetn),
            .axis_valid (axis_valid[i]),
            .axis_accel (axis_accel[i]),
            .axis_ready (axis_ready[i]),
            .vel_valid  (vel_valid[i]),
            .vel_fix    (vel_fix[i]),
            .vel_ready  (vel_ready[i])
        );
    end

    velocity_collector u_coll (
        .us_clk    (us_clk),
        .resetn    (resetn),
        .vel_valid (vel_valid),
        .vel_fix   (vel_fix),
        .vel_ready (vel_ready),
        .vec_valid (vec_valid),
        .vec_data  (vec_data),
        .vec_ready (vec_ready)
    );

endmodule

// File: testbench/tb_auto_mode_checks.sv
// Concurrent assertions and value checks on the auto mode DUT ports, with error counters
`timescale 1ns/1ps

module tb_auto_mode_checks import amc_pkg::*; #(
    parameter int HOLD_TICKS = 40
) (
    input logic       us_clk,
    input logic       resetn,
    input logic       imu_good,
    input logic [7:0] throttle_in,
    input logic       imu_valid,
    input logic       imu_ready,
    input logic [7:0] throttle_out,
    input logic       active,
    input logic       complete,
    input vel_vec_t   velocity,
    input logic       hold_window,
    input vel_vec_t   exp_vel,
    input logic       band_sample
);

    int       assert_errors = 0;
    int       value_errors = 0;
    int       transfers = 0;
    int       completes = 0;
    int       hold_len = 0;
    logic     hold_q = 1'b0;
    vel_vec_t prev_vel = '0;
    logic     xfer;
    logic     quiet;

    assign xfer  = imu_valid && imu_ready;
    assign quiet = !active && !complete && !hold_window && !imu_ready && (throttle_out == 8'h00);

    task automatic report_violation(input string what);
        assert_errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic expect_equal(input string name, input int exp, input int act);
        if (exp != act) begin
            value_errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_vector(input string name, input vel_vec_t exp, input vel_vec_t act);
        expect_equal({name, " x"}, int'(exp.x), int'(act.x));
        expect_equal({name, " y"}, int'(exp.y), int'(act.y));
        expect_equal({name, " z"}, int'(exp.z), int'(act.z));
    endtask

    // One unit toward zero on each axis, zero stays zero
    function automatic vel_vec_t bleed_vector(input vel_vec_t v);
        vel_vec_t r;
        r.x = (v.x > 0) ? v.x - 1 : ((v.x < 0) ? v.x + 1 : v.x);
        r.y = (v.y > 0) ? v.y - 1 : ((v.y < 0) ? v.y + 1 : v.y);
        r.z = (v.z > 0) ? v.z - 1 : ((v.z < 0) ? v.z + 1 : v.z);
        return r;
    endfunction

    always @(posedge us_clk) begin
        if (resetn) begin
            if (xfer)
                transfers <= transfers + 1;
            if (complete) begin
                if (completes == 0)
                    check_vector("zero offset", '0, velocity);
                else if (band_sample)
                    check_vector("deadband bleed", bleed_vector(prev_vel), velocity);
                check_vector("velocity model", exp_vel, velocity);
                completes <= completes + 1;
                prev_vel  <= velocity;
                hold_len  <= 0;
            end else if (hold_window) begin
                hold_len <= hold_len + 1;
            end
            if (hold_q && !hold_window)
                expect_equal("hold window", HOLD_TICKS, hold_len);
            hold_q <= hold_window;
        end
    end

    a_reset_quiet: assert property (@(posedge us_clk) !resetn |-> quiet)
        else report_violation("outputs are not idle during reset");
    a_wait_imu: assert property (@(posedge us_clk) disable iff (!resetn) !imu_good |-> quiet)
        else report_violation("outputs moved before the IMU was good");
    a_active_rise: assert property (@(posedge us_clk) disable iff (!resetn) xfer |=> active)
        else report_violation("active did not rise on the IMU transfer");
    a_active_hold: assert property (
        @(posedge us_clk) disable iff (!resetn) active |=> (active || complete)
    ) else report_violation("active dropped without complete");
    a_one_transfer: assert property (@(posedge us_clk) disable iff (!resetn) xfer |-> !active)
        else report_violation("a second IMU transfer happened while busy");
    a_complete_pulse: assert property (
        @(posedge us_clk) disable iff (!resetn) complete |=> !complete
    ) else report_violation("complete lasted more than one cycle");
    a_throttle: assert property (
        @(posedge us_clk) disable iff (!resetn) xfer |=> (throttle_out == $past(throttle_in))
    ) else report_violation("throttle_out does not match throttle_in at the transfer");
    a_hold_open: assert property (
        @(posedge us_clk) disable iff (!resetn) complete |=> hold_window
    ) else report_violation("hold window did not open after complete");

endmodule

// File: testbench/tb_auto_mode.sv
// Testbench top with clock, reset, random stimulus, velocity reference model, watchdog and report
`timescale 1ns/1ps

module tb_auto_mode import amc_pkg::*; ();

    localparam int HOLD         = 40;
    localparam int DEADBAND     = 20;
    localparam int RESET_CYCLES = 10;
    localparam int N_RANDOM     = 12;
    localparam int N_BAND       = 6;
    localparam int N_STARTS     = 2 + N_RANDOM + N_BAND;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + 20 + N_STARTS * (100 + HOLD)) * 4;
    localparam int DT_LIST [11] = '{12, 13, 15, 19, 20, 22, 23, 25, 26, 27, 31};
    localparam logic signed [31:0] DB_FIX = DEADBAND * 65536;

    logic               us_clk = 1'b0;
    logic               resetn;
    logic               imu_good;
    logic               start_signal;
    logic [7:0]         throttle_in;
    logic               imu_valid;
    imu_sample_t        imu_sample;
    logic               imu_ready;
    logic [7:0]         throttle_out;
    logic               active;
    logic               complete;
    vel_vec_t           velocity;
    logic               hold_window;
    vel_vec_t           exp_vel;
    logic               band_sample;
    logic [31:0]        lcg_state = 32'ha952_fb95;
    logic signed [15:0] base_raw [3];
    logic signed [31:0] model_off [3];
    logic signed [31:0] model_vel [3] = '{0, 0, 0};
    bit                 model_primed = 1'b0;

    auto_mode_top #(.DEADBAND(DEADBAND), .HOLD_TICKS(HOLD)) dut0 (
        .us_clk(us_clk), .resetn(resetn), .imu_good(imu_good), .start_signal(start_signal),
        .throttle_in(throttle_in), .imu_valid(imu_valid), .imu_sample(imu_sample),
        .imu_ready(imu_ready), .throttle_out(throttle_out), .active(active),
        .complete(complete), .velocity(velocity), .hold_window(hold_window)
    );

    tb_auto_mode_checks #(.HOLD_TICKS(HOLD)) checks0 (
        .us_clk(us_clk), .resetn(resetn), .imu_good(imu_good), .throttle_in(throttle_in),
        .imu_valid(imu_valid), .imu_ready(imu_ready), .throttle_out(throttle_out),
        .active(active), .complete(complete), .velocity(velocity), .hold_window(hold_window),
        .exp_vel(exp_vel), .band_sample(band_sample)
    );

    always #2 us_clk = ~us_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'((lcg_next() >> 8) % (hi - lo + 1));
    endfunction

    // Time step of 0.0004 as a sum of arithmetic right shifts
    function automatic logic signed [31:0] shift_sum(input logic signed [31:0] a);
        logic signed [31:0] sum;
        sum = 0;
        foreach (DT_LIST[k])
            sum = sum + (a >>> DT_LIST[k]);
        return sum;
    endfunction

    // Samples sit at a chosen distance from the captured offset of each axis
    function automatic imu_sample_t make_sample(input bit in_band);
        logic signed [15:0] raw [3];
        int delta;
        logic [31:0] sign_draw;
        imu_sample_t s;
        for (int i = 0; i < 3; i++) begin
            delta = in_band ? rand_range(-DEADBAND, DEADBAND) : rand_range(2000, 12000);
            if (!in_band) begin
                sign_draw = lcg_next();
                if (sign_draw[20])
                    delta = -delta;
            end
            raw[i] = base_raw[i] + 16'(delta);
        end
        s.x = raw[0];
        s.y = raw[1];
        s.z = raw[2];
        return s;
    endfunction

    task automatic model_update(input imu_sample_t s);
        logic signed [15:0] raw [3];
        logic signed [31:0] acc;
        logic signed [31:0] zeroed;
        raw = '{s.x, s.y, s.z};
        for (int i = 0; i < 3; i++) begin
            acc = {raw[i], 16'h0000};
            if (!model_primed)
                model_off[i] = acc;
            zeroed = acc - model_off[i];
            if (zeroed > DB_FIX || zeroed < -DB_FIX)
                model_vel[i] = model_vel[i] + shift_sum(zeroed);
            else if ($signed(model_vel[i][31:16]) > 0)
                model_vel[i] = model_vel[i] - 32'sh0001_0000;
            else if ($signed(model_vel[i][31:16]) < 0)
                model_vel[i] = model_vel[i] + 32'sh0001_0000;
        end
        model_primed = 1'b1;
        exp_vel.x = model_vel[0][31:16];
        exp_vel.y = model_vel[1][31:16];
        exp_vel.z = model_vel[2][31:16];
    endtask

    task automatic next_cycle();
        @(posedge us_clk);
        #0.5;
    endtask

    // One start request, one IMU transfer, then wait for the complete pulse
    task automatic run_update(input imu_sample_t s, input bit in_band);
        imu_sample   = s;
        throttle_in  = 8'(lcg_next() >> 16);
        imu_valid    = 1'b1;
        start_signal = 1'b1;
        next_cycle();
        start_signal = 1'b0;
        while (!imu_ready)
            next_cycle();
        // The throttle takes a fresh value just before and just after the transfer
        throttle_in = 8'(lcg_next() >> 16);
        model_update(s);
        band_sample = in_band;
        next_cycle();
        imu_valid   = 1'b0;
        throttle_in = 8'(lcg_next() >> 16);
        while (!complete)
            next_cycle();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all updates finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        resetn       = 1'b1;
        imu_good     = 1'b0;
        start_signal = 1'b0;
        throttle_in  = 8'h00;
        imu_valid    = 1'b0;
        imu_sample   = '0;
        exp_vel      = '0;
        band_sample  = 1'b0;
        #1 resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge us_clk);
        #0.5 resetn = 1'b1;

        // A start held while the IMU is not good must leave the outputs idle
        start_signal = 1'b1;
        repeat (20) next_cycle();
        start_signal = 1'b0;
        imu_good     = 1'b1;

        for (int i = 0; i < 3; i++)
            base_raw[i] = 16'(rand_range(-8000, 8000));
        run_update('{x: base_raw[0], y: base_raw[1], z: base_raw[2]}, 1'b0);
        run_update(make_sample(1'b1), 1'b1);
        repeat (N_RANDOM) run_update(make_sample(1'b0), 1'b0);
        repeat (N_BAND) run_update(make_sample(1'b1), 1'b1);

        // Let the last hold window run out with no new start
        next_cycle();
        while (hold_window)
            next_cycle();
        repeat (2) next_cycle();

        checks0.expect_equal("start handshake", N_STARTS, checks0.transfers);
        checks0.expect_equal("complete count", N_STARTS, checks0.completes);
        $display("Error counts: %0d assertion, %0d value",
                 checks0.assert_errors, checks0.value_errors);
        if (checks0.assert_errors == 0 && checks0.value_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: src.f
rtl/amc_pkg.sv
rtl/auto_mode_sequencer.sv
rtl/imu_axis_splitter.sv
rtl/axis_velocity_integrator.sv
rtl/velocity_collector.sv
rtl/auto_mode_top.sv
testbench/tb_auto_mode_checks.sv
testbench/tb_auto_mode.sv

// File: Bender.yml
package:
  name: auto_mode_ctrl

sources:
  - rtl/amc_pkg.sv
  - rtl/auto_mode_sequencer.sv
  - rtl/imu_axis_splitter.sv
  - rtl/axis_velocity_integrator.sv
  - rtl/velocity_collector.sv
  - rtl/auto_mode_top.sv
  - target: test
    files:
      - testbench/tb_auto_mode_checks.sv
      - testbench/tb_auto_mode.sv
